// File: list.f
hdl/raster_geom_pkg.sv
hdl/raster_ctrl_pkg.sv
hdl/raster_start_timer.sv
hdl/raster_ctrl.sv
hdl/raster_quad_walk.sv
hdl/raster_edge_eval.sv
hdl/raster_out_buf.sv
hdl/raster_unit.sv
dv/raster_tb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing --assert -Wno-fatal
TOP       ?= raster_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "TB PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/raster_tb.sv
// Directed testbench for the tile rasterizer core.
// Expected beats come from a per-pixel model of the edge rule.
// quad_ready is held high, or randomized from a fixed seed in one test.
`timescale 1ns/1ps

module raster_tb;
    import raster_geom_pkg::*;
    import raster_ctrl_pkg::*;

    // Six tile walks, each quad allowed 40 cycles under back-pressure
    localparam int MAX_CYCLES = 6 * QUADS_PER_TILE * 40 + 160;

    logic        clk;
    logic        reset;
    logic        prim_valid;
    tile_idx_t   prim_tile_x;
    tile_idx_t   prim_tile_y;
    edge_coefs_t prim_edges;
    pid_t        prim_pid;
    logic        prim_last;
    logic        quad_ready;
    logic        prim_ready;
    logic        quad_valid;
    coord_t      quad_pos_x;
    coord_t      quad_pos_y;
    mask_t       quad_mask;
    pid_t        quad_pid;
    logic        quad_done;

    integer      seed;
    int          errors;
    int          cycle_cnt;
    logic        rand_ready;
    logic        hold_pend;
    logic [28:0] hold_data;

    coord_t exp_x[$];
    coord_t exp_y[$];
    mask_t  exp_mask[$];
    pid_t   exp_pid[$];
    logic   exp_done[$];
    coord_t act_x[$];
    coord_t act_y[$];
    mask_t  act_mask[$];
    pid_t   act_pid[$];
    logic   act_done[$];

    raster_unit dut0 (
        .clk         (clk),
        .reset       (reset),
        .prim_valid  (prim_valid),
        .prim_tile_x (prim_tile_x),
        .prim_tile_y (prim_tile_y),
        .prim_edges  (prim_edges),
        .prim_pid    (prim_pid),
        .prim_last   (prim_last),
        .quad_ready  (quad_ready),
        .prim_ready  (prim_ready),
        .quad_valid  (quad_valid),
        .quad_pos_x  (quad_pos_x),
        .quad_pos_y  (quad_pos_y),
        .quad_mask   (quad_mask),
        .quad_pid    (quad_pid),
        .quad_done   (quad_done)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        #1;
        if (rand_ready) begin
            quad_ready = (($random(seed) % 2) != 0);
        end else begin
            quad_ready = 1'b1;
        end
    end

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Timeout: run did not complete within %0d cycles", MAX_CYCLES);
            errors = errors + 1;
            report_and_finish();
        end
    end

    // Output monitor; values at the falling edge hold through the next rising edge
    always @(negedge clk) begin
        if (!reset) begin
            if (hold_pend && (!quad_valid || hold_data !=
                    {quad_done, quad_pos_x, quad_pos_y, quad_mask, quad_pid})) begin
                $display("FAILED at %0t: output beat changed before it was accepted", $time);
                errors = errors + 1;
            end
            hold_pend = quad_valid && !quad_ready;
            hold_data = {quad_done, quad_pos_x, quad_pos_y, quad_mask, quad_pid};
            if (quad_valid && quad_ready) begin
                act_x.push_back(quad_pos_x);
                act_y.push_back(quad_pos_y);
                act_mask.push_back(quad_mask);
                act_pid.push_back(quad_pid);
                act_done.push_back(quad_done);
            end
        end
    end

    task automatic check_quad(input int idx, input coord_t got_x, input coord_t want_x,
                              input coord_t got_y, input coord_t want_y,
                              input mask_t got_mask, input mask_t want_mask,
                              input pid_t got_pid, input pid_t want_pid);
        if (got_x !== want_x || got_y !== want_y || got_mask !== want_mask ||
                got_pid !== want_pid) begin
            $display("FAILED at %0t: beat %0d got (%0d,%0d) m%h p%h, want (%0d,%0d) m%h p%h",
                     $time, idx, got_x, got_y, got_mask, got_pid,
                     want_x, want_y, want_mask, want_pid);
            errors = errors + 1;
        end
    endtask

    task automatic check_done(input int idx, input logic got, input logic want);
        if (got !== want) begin
            $display("FAILED at %0t: beat %0d quad_done %b, want %b", $time, idx, got, want);
            errors = errors + 1;
        end
    endtask

    task automatic check_ready(input int edge_num, input logic got, input logic want);
        if (got !== want) begin
            $display("FAILED at %0t: prim_ready %b after edge %0d, want %b",
                     $time, got, edge_num, want);
            errors = errors + 1;
        end
    endtask

    function automatic edge_coefs_t edges_of(input coef_t a0, input coef_t b0, input coef_t c0,
                                             input coef_t a1, input coef_t b1, input coef_t c1,
                                             input coef_t a2, input coef_t b2, input coef_t c2);
        edge_coefs_t e;
        e[0][0] = a0;
        e[0][1] = b0;
        e[0][2] = c0;
        e[1][0] = a1;
        e[1][1] = b1;
        e[1][2] = c1;
        e[2][0] = a2;
        e[2][1] = b2;
        e[2][2] = c2;
        return e;
    endfunction

    function automatic longint edge_at(input edge_coefs_t edges, input int e,
                                       input int x, input int y);
        return longint'(edges[e][0]) * x + longint'(edges[e][1]) * y + longint'(edges[e][2]);
    endfunction

    // Reference model: 8x8 tile as 4x4 quads, row-major, empty quads skipped
    task automatic model_prim(input tile_idx_t tx, input tile_idx_t ty,
                              input edge_coefs_t edges, input pid_t pid);
        int    qx0;
        int    qy0;
        int    px;
        int    py;
        mask_t m;
        for (int q = 0; q < 16; q++) begin
            qx0 = int'(tx) * 8 + (q % 4) * 2;
            qy0 = int'(ty) * 8 + (q / 4) * 2;
            m = '0;
            for (int p = 0; p < 4; p++) begin
                px = qx0 + p % 2;
                py = qy0 + p / 2;
                if (edge_at(edges, 0, px, py) >= 0 && edge_at(edges, 1, px, py) >= 0 &&
                        edge_at(edges, 2, px, py) >= 0) begin
                    m[p] = 1'b1;
                end
            end
            if (m != '0) begin
                exp_x.push_back(coord_t'(qx0));
                exp_y.push_back(coord_t'(qy0));
                exp_mask.push_back(m);
                exp_pid.push_back(pid);
                exp_done.push_back(1'b0);
            end
        end
    endtask

    task automatic model_done();
        exp_x.push_back('0);
        exp_y.push_back('0);
        exp_mask.push_back('0);
        exp_pid.push_back('0);
        exp_done.push_back(1'b1);
    endtask

    task automatic clear_beats();
        exp_x.delete();
        exp_y.delete();
        exp_mask.delete();
        exp_pid.delete();
        exp_done.delete();
        act_x.delete();
        act_y.delete();
        act_mask.delete();
        act_pid.delete();
        act_done.delete();
    endtask

    // Called just after a rising edge; returns just after the transfer edge
    task automatic send_prim(input tile_idx_t tx, input tile_idx_t ty,
                             input edge_coefs_t edges, input pid_t pid, input logic last);
        prim_valid  = 1'b1;
        prim_tile_x = tx;
        prim_tile_y = ty;
        prim_edges  = edges;
        prim_pid    = pid;
        prim_last   = last;
        do begin
            @(negedge clk);
        end while (!prim_ready);
        @(posedge clk);
        #1;
        prim_valid = 1'b0;
        prim_last  = 1'b0;
    endtask

    task automatic wait_and_compare();
        while (act_x.size() < exp_x.size()) begin
            @(posedge clk);
        end
        // Quiet window to catch an extra beat
        repeat (EDGE_LATENCY + 2) @(posedge clk);
        #1;
        if (act_x.size() != exp_x.size()) begin
            $display("FAILED at %0t: got %0d beats, want %0d", $time, act_x.size(), exp_x.size());
            errors = errors + 1;
        end
        for (int i = 0; i < exp_x.size() && i < act_x.size(); i++) begin
            check_done(i, act_done[i], exp_done[i]);
            check_quad(i, act_x[i], exp_x[i], act_y[i], exp_y[i],
                       act_mask[i], exp_mask[i], act_pid[i], exp_pid[i]);
        end
    endtask

    task automatic test_startup();
        for (int k = 1; k <= START_DELAY + 1; k++) begin
            @(posedge clk);
            #1;
            check_ready(k, prim_ready, k == START_DELAY + 1);
        end
    endtask

    task automatic test_full();
        edge_coefs_t e;
        e = edges_of(16'sd0, 16'sd0, 16'sd5, 16'sd0, 16'sd0, 16'sd5, 16'sd0, 16'sd0, 16'sd5);
        clear_beats();
        model_prim(5'd3, 5'd5, e, 8'h21);
        model_done();
        send_prim(5'd3, 5'd5, e, 8'h21, 1'b1);
        wait_and_compare();
    endtask

    task automatic test_partial(input logic random_ready, input pid_t pid);
        edge_coefs_t e;
        // x - y >= 24, x <= 102, y >= 73 across tile (12,9)
        e = edges_of(16'sd1, -16'sd1, -16'sd24, -16'sd1, 16'sd0, 16'sd102,
                     16'sd0, 16'sd1, -16'sd73);
        clear_beats();
        rand_ready = random_ready;
        model_prim(5'd12, 5'd9, e, pid);
        model_done();
        send_prim(5'd12, 5'd9, e, pid, 1'b1);
        wait_and_compare();
        rand_ready = 1'b0;
    endtask

    task automatic test_batches();
        edge_coefs_t full;
        edge_coefs_t none;
        edge_coefs_t diag;
        full = edges_of(16'sd0, 16'sd0, 16'sd1, 16'sd0, 16'sd0, 16'sd1, 16'sd0, 16'sd0, 16'sd1);
        none = edges_of(16'sd0, 16'sd0, -16'sd1, 16'sd0, 16'sd0, -16'sd1,
                        16'sd0, 16'sd0, -16'sd1);
        diag = edges_of(16'sd1, -16'sd1, -16'sd24, -16'sd1, 16'sd0, 16'sd102,
                        16'sd0, 16'sd1, -16'sd73);
        clear_beats();
        model_prim(5'd0, 5'd0, full, 8'h51);
        model_prim(5'd1, 5'd0, none, 8'h52);
        model_done();
        send_prim(5'd0, 5'd0, full, 8'h51, 1'b0);
        send_prim(5'd1, 5'd0, none, 8'h52, 1'b1);
        wait_and_compare();
        // A fresh batch after the done beat
        clear_beats();
        model_prim(5'd12, 5'd9, diag, 8'h53);
        model_done();
        send_prim(5'd12, 5'd9, diag, 8'h53, 1'b1);
        wait_and_compare();
    endtask

    task automatic report_and_finish();
        $display("Run ended with %0d errors after %0d cycles", errors, cycle_cnt);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    endtask

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        prim_valid  = 1'b0;
        prim_tile_x = '0;
        prim_tile_y = '0;
        prim_edges  = '0;
        prim_pid    = '0;
        prim_last   = 1'b0;
        quad_ready  = 1'b1;
        seed        = 66987;
        errors      = 0;
        cycle_cnt   = 0;
        rand_ready  = 1'b0;
        hold_pend   = 1'b0;
        hold_data   = '0;
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;
        test_startup();
        test_full();
        test_partial(1'b0, 8'h34);
        test_partial(1'b1, 8'h35);
        test_batches();
        report_and_finish();
    end

endmodule

// File: hdl/raster_unit.sv
// Tile rasterizer core.
// One primitive per transfer on prim_*, covered quads out on quad_*.
// A done beat follows the last quad of each batch ending in prim_last.
// prim_ready stays low for the startup delay after reset.
`timescale 1ns/1ps

module raster_unit (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         prim_valid,
    input  raster_geom_pkg::tile_idx_t   prim_tile_x,
    input  raster_geom_pkg::tile_idx_t   prim_tile_y,
    input  raster_geom_pkg::edge_coefs_t prim_edges,
    input  raster_geom_pkg::pid_t        prim_pid,
    input  logic                         prim_last,
    input  logic                         quad_ready,
    output logic                         prim_ready,
    output logic                         quad_valid,
    output raster_geom_pkg::coord_t      quad_pos_x,
    output raster_geom_pkg::coord_t      quad_pos_y,
    output raster_geom_pkg::mask_t       quad_mask,
    output raster_geom_pkg::pid_t        quad_pid,
    output logic                         quad_done
);
    import raster_geom_pkg::*;

    logic        start;
    logic        load;
    logic        walk_finish;
    logic        eval_busy;
    logic        buf_ready;
    logic        done_push;
    logic        issue_valid;
    logic        issue_ready;
    coord_t      issue_x;
    coord_t      issue_y;
    edge_coefs_t issue_edges;
    pid_t        issue_pid;
    logic        eval_valid;
    coord_t      eval_x;
    coord_t      eval_y;
    mask_t       eval_mask;
    pid_t        eval_pid;

    raster_start_timer timer0 (
        .clk   (clk),
        .reset (reset),
        .start (start)
    );

    raster_ctrl ctrl0 (
        .clk         (clk),
        .reset       (reset),
        .start       (start),
        .prim_valid  (prim_valid),
        .prim_last   (prim_last),
        .walk_finish (walk_finish),
        .eval_busy   (eval_busy),
        .buf_ready   (buf_ready),
        .prim_ready  (prim_ready),
        .load        (load),
        .done_push   (done_push)
    );

    raster_quad_walk walk0 (
        .clk         (clk),
        .reset       (reset),
        .load        (load),
        .prim_tile_x (prim_tile_x),
        .prim_tile_y (prim_tile_y),
        .prim_edges  (prim_edges),
        .prim_pid    (prim_pid),
        .issue_ready (issue_ready),
        .issue_valid (issue_valid),
        .issue_x     (issue_x),
        .issue_y     (issue_y),
        .issue_edges (issue_edges),
        .issue_pid   (issue_pid),
        .walk_finish (walk_finish)
    );

    raster_edge_eval eval0 (
        .clk         (clk),
        .reset       (reset),
        .issue_valid (issue_valid),
        .issue_x     (issue_x),
        .issue_y     (issue_y),
        .issue_edges (issue_edges),
        .issue_pid   (issue_pid),
        .buf_ready   (buf_ready),
        .issue_ready (issue_ready),
        .eval_valid  (eval_valid),
        .eval_x      (eval_x),
        .eval_y      (eval_y),
        .eval_mask   (eval_mask),
        .eval_pid    (eval_pid),
        .eval_busy   (eval_busy)
    );

    raster_out_buf buf0 (
        .clk        (clk),
        .reset      (reset),
        .eval_valid (eval_valid),
        .eval_x     (eval_x),
        .eval_y     (eval_y),
        .eval_mask  (eval_mask),
        .eval_pid   (eval_pid),
        .done_push  (done_push),
        .quad_ready (quad_ready),
        .buf_ready  (buf_ready),
        .quad_valid (quad_valid),
        .quad_pos_x (quad_pos_x),
        .quad_pos_y (quad_pos_y),
        .quad_mask  (quad_mask),
        .quad_pid   (quad_pid),
        .quad_done  (quad_done)
    );

endmodule

// File: hdl/raster_out_buf.sv
// Two-entry output queue; the head entry drives the quad bus directly.
// Takes either a quad beat or a done beat per cycle, never both.
// buf_ready depends only on queue state, not on quad_ready.
// Done beats carry zero position, mask and pid.
`timescale 1ns/1ps

module raster_out_buf (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    eval_valid,
    input  raster_geom_pkg::coord_t eval_x,
    input  raster_geom_pkg::coord_t eval_y,
    input  raster_geom_pkg::mask_t  eval_mask,
    input  raster_geom_pkg::pid_t   eval_pid,
    input  logic                    done_push,
    input  logic                    quad_ready,
    output logic                    buf_ready,
    output logic                    quad_valid,
    output raster_geom_pkg::coord_t quad_pos_x,
    output raster_geom_pkg::coord_t quad_pos_y,
    output raster_geom_pkg::mask_t  quad_mask,
    output raster_geom_pkg::pid_t   quad_pid,
    output logic                    quad_done
);
    import raster_geom_pkg::*;

    logic   push;
    logic   pop;
    logic   tail_valid;
    logic   tail_done;
    coord_t tail_x;
    coord_t tail_y;
    mask_t  tail_mask;
    pid_t   tail_pid;
    coord_t in_x;
    coord_t in_y;
    mask_t  in_mask;
    pid_t   in_pid;

    assign buf_ready = !tail_valid;
    assign push      = (eval_valid || done_push) && buf_ready;
    assign pop       = quad_valid && quad_ready;

    assign in_x    = eval_valid ? eval_x : '0;
    assign in_y    = eval_valid ? eval_y : '0;
    assign in_mask = eval_valid ? eval_mask : '0;
    assign in_pid  = eval_valid ? eval_pid : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            quad_valid <= 1'b0;
            tail_valid <= 1'b0;
        end else begin
            quad_valid <= push || tail_valid || (quad_valid && !pop);
            tail_valid <= (push && quad_valid && !pop) || (tail_valid && !pop);
        end
    end

    // A push never meets a full queue, so tail refill and tail-to-head never collide
    always_ff @(posedge clk) begin
        if (pop && tail_valid) begin
            {quad_done, quad_pos_x, quad_pos_y, quad_mask, quad_pid}
                <= {tail_done, tail_x, tail_y, tail_mask, tail_pid};
        end else if (push && (!quad_valid || pop)) begin
            {quad_done, quad_pos_x, quad_pos_y, quad_mask, quad_pid}
                <= {done_push, in_x, in_y, in_mask, in_pid};
        end
        if (push && quad_valid && !pop) begin
            {tail_done, tail_x, tail_y, tail_mask, tail_pid}
                <= {done_push, in_x, in_y, in_mask, in_pid};
        end
    end

    a_one_source: assert property (
        @(posedge clk) disable iff (reset)
        !(eval_valid && done_push)
    );

    a_out_stable: assert property (
        @(posedge clk) disable iff (reset)
        (quad_valid && !quad_ready) |=>
            quad_valid && $stable({quad_done, quad_pos_x, quad_pos_y, quad_mask, quad_pid})
    );

endmodule

// File: hdl/raster_edge_eval.sv
// Two-stage edge evaluator.
// Stage 1 multiplies a and b by the quad's pixel coordinates.
// Stage 2 adds c and tests all three edges for the four pixels.
// Both stages stall together while a covered quad waits on buf_ready.
// Quads with no covered pixel are dropped at the output.
`timescale 1ns/1ps

module raster_edge_eval (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         issue_valid,
    input  raster_geom_pkg::coord_t      issue_x,
    input  raster_geom_pkg::coord_t      issue_y,
    input  raster_geom_pkg::edge_coefs_t issue_edges,
    input  raster_geom_pkg::pid_t        issue_pid,
    input  logic                         buf_ready,
    output logic                         issue_ready,
    output logic                         eval_valid,
    output raster_geom_pkg::coord_t      eval_x,
    output raster_geom_pkg::coord_t      eval_y,
    output raster_geom_pkg::mask_t       eval_mask,
    output raster_geom_pkg::pid_t        eval_pid,
    output logic                         eval_busy
);
    import raster_geom_pkg::*;

    logic      enable;
    logic      s1_valid;
    logic      s2_valid;
    coord_t    s1_x;
    coord_t    s1_y;
    pid_t      s1_pid;
    edge_val_t s1_ax [3][2];
    edge_val_t s1_by [3][2];
    edge_val_t s1_c  [3];
    mask_t     mask_next;

    function automatic edge_val_t scale(coef_t k, logic [8:0] p);
        return edge_val_t'(k) * edge_val_t'(p);
    endfunction

    assign eval_valid  = s2_valid && (eval_mask != '0);
    assign enable      = !(eval_valid && !buf_ready);
    assign issue_ready = enable;
    assign eval_busy   = s1_valid || s2_valid;

    always_comb begin
        edge_val_t sum;
        mask_next = '1;
        for (int p = 0; p < 4; p++) begin
            for (int e = 0; e < 3; e++) begin
                sum = s1_ax[e][p % 2] + s1_by[e][p / 2] + s1_c[e];
                if (sum < 0) mask_next[p] = 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else if (enable) begin
            s1_valid <= issue_valid;
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (enable) begin
            s1_x   <= issue_x;
            s1_y   <= issue_y;
            s1_pid <= issue_pid;
            for (int e = 0; e < 3; e++) begin
                s1_ax[e][0] <= scale(issue_edges[e][0], {1'b0, issue_x});
                s1_ax[e][1] <= scale(issue_edges[e][0], {1'b0, issue_x} + 9'd1);
                s1_by[e][0] <= scale(issue_edges[e][1], {1'b0, issue_y});
                s1_by[e][1] <= scale(issue_edges[e][1], {1'b0, issue_y} + 9'd1);
                s1_c[e]     <= edge_val_t'(issue_edges[e][2]);
            end
            eval_x    <= s1_x;
            eval_y    <= s1_y;
            eval_pid  <= s1_pid;
            eval_mask <= mask_next;
        end
    end

endmodule

// File: hdl/raster_quad_walk.sv
// Quad walker.
// Holds the loaded primitive and issues the tile's quads in row-major order,
// one per cycle unless issue_ready is low.
// load must only arrive while no tile is being walked.
`timescale 1ns/1ps

module raster_quad_walk (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         load,
    input  raster_geom_pkg::tile_idx_t   prim_tile_x,
    input  raster_geom_pkg::tile_idx_t   prim_tile_y,
    input  raster_geom_pkg::edge_coefs_t prim_edges,
    input  raster_geom_pkg::pid_t        prim_pid,
    input  logic                         issue_ready,
    output logic                         issue_valid,
    output raster_geom_pkg::coord_t      issue_x,
    output raster_geom_pkg::coord_t      issue_y,
    output raster_geom_pkg::edge_coefs_t issue_edges,
    output raster_geom_pkg::pid_t        issue_pid,
    output logic                         walk_finish
);
    import raster_geom_pkg::*;

    logic      active;
    logic      fire;
    quad_idx_t quad_idx;
    tile_idx_t tile_x;
    tile_idx_t tile_y;

    assign issue_valid = active;
    assign fire        = active && issue_ready;
    assign walk_finish = fire && (quad_idx == quad_idx_t'(QUADS_PER_TILE - 1));

    // Tile origin plus twice the quad column / row
    assign issue_x = (coord_t'(tile_x) << TILE_LOGSIZE)
                   + coord_t'({quad_idx[QUAD_COL_BITS-1:0], 1'b0});
    assign issue_y = (coord_t'(tile_y) << TILE_LOGSIZE)
                   + coord_t'({quad_idx[2*QUAD_COL_BITS-1:QUAD_COL_BITS], 1'b0});

    always_ff @(posedge clk) begin
        if (reset) begin
            active   <= 1'b0;
            quad_idx <= '0;
        end else if (load) begin
            active   <= 1'b1;
            quad_idx <= '0;
        end else if (fire) begin
            quad_idx <= quad_idx + 1'b1;
            if (walk_finish) active <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            tile_x      <= prim_tile_x;
            tile_y      <= prim_tile_y;
            issue_edges <= prim_edges;
            issue_pid   <= prim_pid;
        end
    end

    a_hold_on_stall: assert property (
        @(posedge clk) disable iff (reset)
        (issue_valid && !issue_ready) |=> quad_idx == $past(quad_idx)
    );

endmodule

// File: hdl/raster_ctrl.sv
// Batch controller.
// Accepts one primitive at a time, only while IDLE.
// After the primitive flagged last, waits for the evaluator to empty
// and then holds done_push until the output queue takes it.
`timescale 1ns/1ps

module raster_ctrl (
    input  logic clk,
    input  logic reset,
    input  logic start,
    input  logic prim_valid,
    input  logic prim_last,
    input  logic walk_finish,
    input  logic eval_busy,
    input  logic buf_ready,
    output logic prim_ready,
    output logic load,
    output logic done_push
);
    import raster_geom_pkg::*;
    import raster_ctrl_pkg::*;

    ctrl_state_t state;
    ctrl_state_t state_next;
    logic        last_q;
    quad_idx_t   scan_cnt;

    assign prim_ready = (state == IDLE);
    assign load       = prim_valid && prim_ready;
    assign done_push  = (state == DONE);

    always_comb begin
        state_next = state;
        case (state)
            WAIT_START: if (start) state_next = IDLE;
            IDLE:       if (load) state_next = SCAN;
            SCAN:       if (walk_finish) state_next = last_q ? DRAIN : IDLE;
            DRAIN:      if (!eval_busy) state_next = DONE;
            DONE:       if (buf_ready) state_next = IDLE;
            default:    state_next = WAIT_START;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= WAIT_START;
            last_q   <= 1'b0;
            scan_cnt <= '0;
        end else begin
            state <= state_next;
            if (load) begin
                last_q   <= prim_last;
                scan_cnt <= '0;
            end else if (state == SCAN && scan_cnt != '1) begin
                scan_cnt <= scan_cnt + 1'b1;
            end
        end
    end

    a_load_idle: assert property (
        @(posedge clk) disable iff (reset)
        load |-> state == IDLE
    );

    // Walker cannot finish a tile faster than one quad per cycle
    a_walk_min: assert property (
        @(posedge clk) disable iff (reset)
        walk_finish |-> state == SCAN && scan_cnt == quad_idx_t'(QUADS_PER_TILE - 1)
    );

endmodule

// File: hdl/raster_start_timer.sv
// Startup delay after reset.
// start pulses for one cycle START_DELAY cycles after reset is released,
// then stays low until the next reset.
`timescale 1ns/1ps

module raster_start_timer (
    input  logic clk,
    input  logic reset,
    output logic start
);
    import raster_ctrl_pkg::*;

    start_cnt_t start_cnt;

    always_ff @(posedge clk) begin
        if (reset) begin
            start_cnt <= start_cnt_t'(START_DELAY);
            start     <= 1'b0;
        end else begin
            if (start_cnt != '0) begin
                start_cnt <= start_cnt - 1'b1;
            end
            // Fires as the count reaches zero
            start <= (start_cnt == start_cnt_t'(1));
        end
    end

    a_start_single: assert property (
        @(posedge clk) disable iff (reset)
        start |=> !start
    );

endmodule

// File: hdl/raster_ctrl_pkg.sv
// Controller states and startup timing.
// START_DELAY gives reset time to settle through the hierarchy
// before the first primitive is accepted.
package raster_ctrl_pkg;

    localparam int START_DELAY = 16;

    typedef logic [$clog2(START_DELAY+1)-1:0] start_cnt_t;

    typedef enum logic [2:0] {
        WAIT_START,
        IDLE,
        SCAN,
        DRAIN,
        DONE
    } ctrl_state_t;

endpackage

// File: hdl/raster_geom_pkg.sv
// Geometry types shared by the rasterizer datapath.
// The tile is fixed at 8x8 pixels, walked as 2x2 quads.
// Edge values are wide enough for any 16-bit coefficient at any 8-bit coordinate.
package raster_geom_pkg;

    // Tile edge is 1 << TILE_LOGSIZE pixels
    localparam int TILE_LOGSIZE = 3;

    // Quad column (or row) index bits within a tile
    localparam int QUAD_COL_BITS = TILE_LOGSIZE - 1;

    localparam int QUADS_PER_TILE = 1 << (2 * QUAD_COL_BITS);

    // Evaluator pipeline depth
    localparam int EDGE_LATENCY = 2;

    typedef logic [7:0] coord_t;

    typedef logic [4:0] tile_idx_t;

    typedef logic [2*QUAD_COL_BITS-1:0] quad_idx_t;

    typedef logic signed [15:0] coef_t;

    typedef logic signed [33:0] edge_val_t;

    // Indexed [edge][coef], coef 0 = a, 1 = b, 2 = c
    typedef coef_t [2:0][2:0] edge_coefs_t;

    // Bit 0 (x,y), bit 1 (x+1,y), bit 2 (x,y+1), bit 3 (x+1,y+1)
    typedef logic [3:0] mask_t;

    typedef logic [7:0] pid_t;

endpackage
